// ==== Bender.yml ====
package:
  name: soc_bus

export_include_dirs:
  - rtl

sources:
  - rtl/soc_bus_pkg.sv
  - rtl/soc_bus_if.sv
  - rtl/bus_arbiter.sv
  - rtl/dbus_decoder.sv
  - rtl/ram_slave.sv
  - rtl/gpio_slave.sv
  - rtl/ticker_slave.sv
  - rtl/soc_bus_top.sv
  - target: simulation
    files:
      - dv/soc_bus_chk.sv
      - dv/soc_bus_tb.sv

// ==== dv/soc_bus_chk.sv ====
`default_nettype none

module soc_bus_chk import soc_bus_pkg::*; (
    input wire        clk_i,
    input wire        rst_i,
    input wire        bus_read,
    input wire        bus_write,
    input wire        ram_rd,
    input wire        ram_wr,
    input wire        ram_stall,
    input wire        gpio_rd,
    input wire        gpio_wr,
    input wire        tick_rd,
    input wire        tick_wr,
    input arb_state_e arb_state
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [5:0] strobes;
    logic       ram_req;

    assign strobes = {ram_rd, ram_wr, gpio_rd, gpio_wr, tick_rd, tick_wr};
    assign ram_req = ram_rd | ram_wr;

    // ************************************************************************
    // bus and strobe rules
    // ************************************************************************
    a_one_strobe: assert property (@(posedge clk_i) $onehot0(strobes))
        else $error("more than one slave strobe high");
    a_rd_wr: assert property (@(posedge clk_i) !(bus_read && bus_write))
        else $error("read and write high together on the bus");
    a_rst_quiet: assert property (@(posedge clk_i) rst_i |-> strobes == '0)
        else $error("strobe high during reset");

    // one stall cycle, then completion
    a_ram_wait: assert property (@(posedge clk_i) disable iff (rst_i)
        ram_req && ram_stall |=> ram_req && !ram_stall)
        else $error("ram access did not complete after one stall");
    a_lock_req: assert property (@(posedge clk_i) disable iff (rst_i)
        arb_state != ARB_IDLE |-> bus_read || bus_write)
        else $error("grant locked with no request");

endmodule

bind soc_bus_top soc_bus_chk u_chk (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .bus_read  (sys_bus.read),
    .bus_write (sys_bus.write),
    .ram_rd    (ram_bus.rd),
    .ram_wr    (ram_bus.wr),
    .ram_stall (ram_bus.stall),
    .gpio_rd   (gpio_bus.rd),
    .gpio_wr   (gpio_bus.wr),
    .tick_rd   (ticker_bus.rd),
    .tick_wr   (ticker_bus.wr),
    .arb_state (u_arbiter.state_q)
);

`default_nettype wire

// ==== dv/soc_bus_tb.sv ====
`include "soc_bus_consts.svh"
`default_nettype none

module soc_bus_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum {OP_RD, OP_WR} op_e;
    typedef enum {K_WRITE, K_RAM, K_GPIO, K_PINS, K_TLOAD, K_TICK, K_UNMAP} kind_e;

    logic        clk_i = 1'b0;
    logic        rst_i = 1'b1;
    logic [31:0] m_addr [2];
    logic [3:0]  m_be [2];
    logic        m_read [2];
    logic        m_write [2];
    logic [31:0] m_wdata [2];
    logic [31:0] m0_rdata_o, m1_rdata_o, gpio_i, gpio_o;
    logic        m0_stall_o, m1_stall_o;

    int          tab_m [32];
    op_e         tab_op [32];
    logic [31:0] tab_addr [32];
    logic [3:0]  tab_be [32];
    logic [31:0] tab_wd [32];
    kind_e       tab_kind [32];
    int          n_tab = 0;
    int          errors = 0;
    int          cyc = 0;
    logic [31:0] ram_model [int];
    logic [31:0] gpio_model = '0;
    logic [31:0] pins_val = '0;
    logic [31:0] tick_v = '0;
    int          tick_cyc = 0;
    int          order [$];

    soc_bus_top u_dut (
        .clk_i(clk_i), .rst_i(rst_i),
        .m0_addr_i(m_addr[0]), .m0_be_i(m_be[0]), .m0_read_i(m_read[0]),
        .m0_write_i(m_write[0]), .m0_wdata_i(m_wdata[0]),
        .m0_rdata_o(m0_rdata_o), .m0_stall_o(m0_stall_o),
        .m1_addr_i(m_addr[1]), .m1_be_i(m_be[1]), .m1_read_i(m_read[1]),
        .m1_write_i(m_write[1]), .m1_wdata_i(m_wdata[1]),
        .m1_rdata_o(m1_rdata_o), .m1_stall_o(m1_stall_o),
        .gpio_i(gpio_i), .gpio_o(gpio_o)
    );

    always #50 clk_i = ~clk_i;
    always @(posedge clk_i) cyc <= cyc + 1;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic add_entry(input int m, input op_e op, input logic [31:0] addr,
                             input logic [3:0] be, input kind_e kind);
        tab_m[n_tab]    = m;
        tab_op[n_tab]   = op;
        tab_addr[n_tab] = addr;
        tab_be[n_tab]   = be;
        tab_wd[n_tab]   = $urandom() & 32'h0fff_ffff;  // headroom for the ticker
        tab_kind[n_tab] = kind;
        n_tab++;
    endtask

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wd,
                                          input logic [3:0] be);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) r[8*b +: 8] = wd[8*b +: 8];
        end
        return r;
    endfunction

    // model update for a completed write, using the address map
    task automatic model_write(input logic [31:0] addr, input logic [31:0] wd,
                               input logic [3:0] be);
        if (addr[31:24] == 8'h00) begin
            ram_model[addr[9:2]] = merge(ram_model[addr[9:2]], wd, be);
        end else if (addr == `SOC_GPIO_BASE) begin
            gpio_model = merge(gpio_model, wd, be);
        end
    endtask

    task automatic drive_master(input int m, input op_e op, input logic [31:0] addr,
                                input logic [3:0] be, input logic [31:0] wd);
        m_addr[m]  <= addr;
        m_be[m]    <= be;
        m_wdata[m] <= wd;
        m_read[m]  <= (op == OP_RD);
        m_write[m] <= (op == OP_WR);
    endtask

    task automatic release_master(input int m);
        m_read[m]  <= 1'b0;
        m_write[m] <= 1'b0;
    endtask

    function automatic logic stall_of(input int m);
        return m ? m1_stall_o : m0_stall_o;
    endfunction

    // single access, returns data and the number of cycles it took
    task automatic access(input int m, input op_e op, input logic [31:0] addr,
                          input logic [3:0] be, input logic [31:0] wd,
                          output logic [31:0] rd, output int n, output bit ok);
        @(posedge clk_i);
        drive_master(m, op, addr, be, wd);
        n  = 0;
        ok = 0;
        while (n < 20 && !ok) begin
            @(negedge clk_i);
            n++;
            if (!stall_of(m)) begin
                ok = 1;
                rd = m ? m1_rdata_o : m0_rdata_o;
            end
        end
        @(posedge clk_i);
        release_master(m);
        if (!ok) begin
            $display("Timeout: master %0d access to %h never completed", m, addr);
            errors++;
        end
    endtask

    // access number s of master m in the contention stream
    task automatic stream_step(input int m, input int s, output op_e op,
                               output logic [31:0] addr);
        if (m == 0) begin
            op   = (s % 2 == 0) ? OP_RD : OP_WR;
            addr = (s % 2 == 0) ? 32'h0000_000c : 32'h0000_0080 + 4 * (s / 2);
        end else begin
            op   = (s % 2 == 0) ? OP_WR : OP_RD;
            addr = (s % 2 == 0) ? 32'h0000_0040 + 4 * (s / 2) : 32'h0000_0028;
        end
    endtask

    // both masters start in the same cycle and re-request right after
    // each completion, so every arbitration is contended
    task automatic contend(input int steps);
        op_e         op [2];
        logic [31:0] addr [2];
        logic [31:0] wd [2];
        int          step [2];
        bit          busy [2];
        bit          fin [2];
        int          n;
        @(posedge clk_i);
        for (int m = 0; m < 2; m++) begin
            step[m] = 0;
            busy[m] = 1;
            fin[m]  = 0;
            stream_step(m, 0, op[m], addr[m]);
            wd[m] = $urandom();
            drive_master(m, op[m], addr[m], 4'hf, wd[m]);
        end
        n = 0;
        while ((busy[0] || busy[1]) && n < 20) begin
            @(negedge clk_i);
            n++;
            for (int m = 0; m < 2; m++) begin
                if (busy[m] && !stall_of(m)) begin
                    fin[m] = 1;
                    n      = 0;
                    order.push_back(m);
                    if (op[m] == OP_RD) begin
                        compare(m ? "m1_rdata_o" : "m0_rdata_o",
                                m ? m1_rdata_o : m0_rdata_o, ram_model[addr[m][9:2]]);
                    end else begin
                        model_write(addr[m], wd[m], 4'hf);
                    end
                end
            end
            @(posedge clk_i);
            for (int m = 0; m < 2; m++) begin
                if (fin[m]) begin
                    fin[m] = 0;
                    step[m]++;
                    if (step[m] < steps) begin
                        stream_step(m, step[m], op[m], addr[m]);
                        wd[m] = $urandom();
                        drive_master(m, op[m], addr[m], 4'hf, wd[m]);
                    end else begin
                        busy[m] = 0;
                        release_master(m);
                    end
                end
            end
        end
        if (busy[0] || busy[1]) begin
            $display("Timeout: contended accesses did not all complete");
            errors++;
        end
    endtask

    initial begin
        logic [31:0] rd;
        int          n, e0;
        bit          ok;
        string       rd_name;
        void'($urandom(32'h20bb3885));
        for (int m = 0; m < 2; m++) begin
            m_addr[m]  = '0;
            m_be[m]    = '0;
            m_read[m]  = 1'b0;
            m_write[m] = 1'b0;
            m_wdata[m] = '0;
        end
        gpio_i = '0;

        // ********************************************************************
        // stimulus table
        // ********************************************************************
        add_entry(1, OP_WR, 32'h0000_000c, 4'hf, K_WRITE);
        add_entry(1, OP_WR, 32'h0000_000c, 4'h3, K_WRITE);
        add_entry(0, OP_WR, 32'h0000_000c, 4'h8, K_WRITE);
        add_entry(0, OP_RD, 32'h0000_000c, 4'hf, K_RAM);
        add_entry(1, OP_WR, 32'h0000_0028, 4'hf, K_WRITE);
        add_entry(1, OP_WR, 32'h0000_0028, 4'h6, K_WRITE);
        add_entry(1, OP_RD, 32'h0000_0028, 4'hf, K_RAM);
        add_entry(1, OP_WR, 32'h0000_0320, 4'hf, K_WRITE);
        add_entry(1, OP_WR, `SOC_GPIO_BASE, 4'hf, K_GPIO);
        add_entry(0, OP_WR, `SOC_GPIO_BASE, 4'h5, K_GPIO);
        add_entry(1, OP_RD, `SOC_GPIO_BASE, 4'hf, K_GPIO);
        add_entry(1, OP_RD, `SOC_GPIO_BASE + 4, 4'hf, K_PINS);
        add_entry(1, OP_WR, `SOC_TICKER_BASE, 4'hf, K_TLOAD);
        add_entry(0, OP_RD, `SOC_TICKER_BASE, 4'hf, K_TICK);
        add_entry(1, OP_RD, 32'h3000_0000, 4'hf, K_UNMAP);
        add_entry(1, OP_WR, 32'h3000_000c, 4'hf, K_UNMAP);
        add_entry(0, OP_WR, 32'h1fd0_0600, 4'hf, K_UNMAP);
        add_entry(0, OP_RD, 32'h0000_000c, 4'hf, K_RAM);
        add_entry(1, OP_RD, 32'h0000_0320, 4'hf, K_RAM);
        add_entry(0, OP_RD, `SOC_GPIO_BASE, 4'hf, K_GPIO);

        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;

        for (int i = 0; i < n_tab; i++) begin
            e0 = errors;
            rd_name = tab_m[i] ? "m1_rdata_o" : "m0_rdata_o";
            if (tab_kind[i] == K_PINS) begin
                @(posedge clk_i);
                pins_val = $urandom();
                gpio_i <= pins_val;
                repeat (2) @(posedge clk_i);
            end
            access(tab_m[i], tab_op[i], tab_addr[i], tab_be[i], tab_wd[i], rd, n, ok);
            if (ok) begin
                if (tab_op[i] == OP_WR) model_write(tab_addr[i], tab_wd[i], tab_be[i]);
                case (tab_kind[i])
                    K_RAM:   compare(rd_name, rd, ram_model[tab_addr[i][9:2]]);
                    K_PINS:  compare(rd_name, rd, pins_val);
                    K_GPIO: begin
                        if (tab_op[i] == OP_RD) compare(rd_name, rd, gpio_model);
                        @(negedge clk_i);
                        compare("gpio_o", gpio_o, gpio_model);
                    end
                    K_TLOAD: begin
                        tick_v   = tab_wd[i];
                        tick_cyc = cyc - 1;     // completion cycle, sampled after its edge
                    end
                    K_TICK: begin
                        if (!(rd > tick_v && rd <= tick_v + (cyc - 1 - tick_cyc))) begin
                            $display("Ticker read %h is out of range after load of %h",
                                     rd, tick_v);
                            errors++;
                        end
                    end
                    K_UNMAP: begin
                        if (tab_op[i] == OP_RD) compare(rd_name, rd, 32'h0);
                        if (n != 1) begin
                            $display("Unmapped access took %0d cycles instead of one", n);
                            errors++;
                        end
                    end
                    default: ;
                endcase
            end
            $display("test %0d %s %h: %s", i, tab_op[i].name(), tab_addr[i],
                     (errors == e0) ? "ok" : "FAIL");
        end

        // ********************************************************************
        // contention, back to back
        // ********************************************************************
        e0 = errors;
        contend(6);
        for (int k = 1; k < order.size(); k++) begin
            if (order[k] == order[k-1]) begin
                $display("Completions did not alternate at position %0d", k);
                errors++;
            end
        end
        $display("test contention: %s", (errors == e0) ? "ok" : "FAIL");

        $display("%0d tests, %0d errors", n_tab + 1, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/bus_arbiter.sv ====
`include "soc_bus_consts.svh"
`default_nettype none

module bus_arbiter import soc_bus_pkg::*; (
    input  wire                   clk_i,
    input  wire                   rst_i,

    input  wire [`SOC_BUS_AW-1:0] m0_addr_i,
    input  wire [`SOC_BUS_BW-1:0] m0_be_i,
    input  wire                   m0_read_i,
    input  wire                   m0_write_i,
    input  wire [`SOC_BUS_DW-1:0] m0_wdata_i,
    output logic [`SOC_BUS_DW-1:0] m0_rdata_o,
    output logic                  m0_stall_o,

    input  wire [`SOC_BUS_AW-1:0] m1_addr_i,
    input  wire [`SOC_BUS_BW-1:0] m1_be_i,
    input  wire                   m1_read_i,
    input  wire                   m1_write_i,
    input  wire [`SOC_BUS_DW-1:0] m1_wdata_i,
    output logic [`SOC_BUS_DW-1:0] m1_rdata_o,
    output logic                  m1_stall_o,

    bus_if.master                 bus
);

    arb_state_e state_q;
    logic       prio_q;                // 1 gives m1 the tie
    logic       m0_req;
    logic       m1_req;
    logic       gnt_m1;                // 0 means m0 owns the bus
    logic       done;

    assign m0_req = m0_read_i | m0_write_i;
    assign m1_req = m1_read_i | m1_write_i;

    always_comb begin
        case (state_q)
            ARB_M0:  gnt_m1 = 1'b0;
            ARB_M1:  gnt_m1 = 1'b1;
            default: gnt_m1 = (m0_req && m1_req) ? prio_q : m1_req;
        endcase
    end

    // ************************************************************************
    // bus mux
    // ************************************************************************
    always_comb begin
        if (gnt_m1) begin
            bus.addr  = m1_addr_i;
            bus.be    = m1_be_i;
            bus.read  = m1_read_i;
            bus.write = m1_write_i;
            bus.wdata = m1_wdata_i;
        end else begin
            bus.addr  = m0_addr_i;
            bus.be    = m0_be_i;
            bus.read  = m0_read_i;
            bus.write = m0_write_i;
            bus.wdata = m0_wdata_i;
        end
    end

    assign m0_rdata_o = bus.rdata;
    assign m1_rdata_o = bus.rdata;
    assign m0_stall_o = gnt_m1 ? m0_req : (m0_req & bus.stall);  // loser waits
    assign m1_stall_o = gnt_m1 ? (m1_req & bus.stall) : m1_req;

    assign done = (bus.read | bus.write) & ~bus.stall;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ARB_IDLE;
            prio_q  <= 1'b0;
        end else if (done) begin
            state_q <= ARB_IDLE;
            prio_q  <= ~gnt_m1;        // hand the tie to the other side
        end else if (state_q == ARB_IDLE && (m0_req || m1_req)) begin
            state_q <= gnt_m1 ? ARB_M1 : ARB_M0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dbus_decoder.sv ====
`include "soc_bus_consts.svh"
`default_nettype none

module dbus_decoder import soc_bus_pkg::*; (
    bus_if.slave    bus,
    slave_if.master ram,
    slave_if.master gpio,
    slave_if.master ticker
);

    localparam logic [`SOC_BUS_AW-1:0] GPIO_BASE   = `SOC_GPIO_BASE;
    localparam logic [`SOC_BUS_AW-1:0] TICKER_BASE = `SOC_TICKER_BASE;

    slave_sel_e sel;

    always_comb begin
        if (bus.addr[31:24] == `SOC_RAM_TAG) begin
            sel = SEL_RAM;
        end else if (bus.addr[31:8] == GPIO_BASE[31:8]) begin
            sel = SEL_GPIO;
        end else if (bus.addr[31:8] == TICKER_BASE[31:8]) begin
            sel = SEL_TICKER;
        end else begin
            sel = SEL_NONE;
        end
    end

    // ************************************************************************
    // forward path, shared by every slave
    // ************************************************************************
    assign ram.off      = bus.addr[`SOC_RAM_OW+1:2];  // aliases past the depth
    assign ram.be       = bus.be;
    assign ram.wdata    = bus.wdata;

    assign gpio.off     = bus.addr[`SOC_IO_OW+1:2];
    assign gpio.be      = bus.be;
    assign gpio.wdata   = bus.wdata;

    assign ticker.off   = bus.addr[`SOC_IO_OW+1:2];
    assign ticker.be    = bus.be;
    assign ticker.wdata = bus.wdata;

    // ************************************************************************
    // strobes and return path
    // ************************************************************************
    always_comb begin
        ram.rd    = 1'b0;
        ram.wr    = 1'b0;
        gpio.rd   = 1'b0;
        gpio.wr   = 1'b0;
        ticker.rd = 1'b0;
        ticker.wr = 1'b0;
        bus.rdata = '0;                // unmapped reads zero
        bus.stall = 1'b0;
        case (sel)
            SEL_RAM: begin
                ram.rd    = bus.read;
                ram.wr    = bus.write;
                bus.rdata = ram.rdata;
                bus.stall = ram.stall;
            end
            SEL_GPIO: begin
                gpio.rd   = bus.read;
                gpio.wr   = bus.write;
                bus.rdata = gpio.rdata;
                bus.stall = gpio.stall;
            end
            SEL_TICKER: begin
                ticker.rd = bus.read;
                ticker.wr = bus.write;
                bus.rdata = ticker.rdata;
                bus.stall = ticker.stall;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/gpio_slave.sv ====
`include "soc_bus_consts.svh"
`default_nettype none

module gpio_slave (
    input  wire                    clk_i,
    input  wire                    rst_i,
    slave_if.slave                 port,
    input  wire [`SOC_BUS_DW-1:0]  gpio_i,
    output logic [`SOC_BUS_DW-1:0] gpio_o
);

    logic [`SOC_BUS_DW-1:0] out_q;
    logic [`SOC_BUS_DW-1:0] in_q;      // pins, one cycle late

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_q <= '0;
        end else if (port.wr && port.off == '0) begin
            for (int b = 0; b < `SOC_BUS_BW; b++) begin
                if (port.be[b]) begin
                    out_q[8*b +: 8] <= port.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        in_q <= gpio_i;
    end

    assign gpio_o     = out_q;
    assign port.stall = 1'b0;

    always_comb begin
        port.rdata = '0;
        if (port.rd) begin
            case (port.off)
                'd0:     port.rdata = out_q;
                'd1:     port.rdata = in_q;  // offset 4
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ram_slave.sv ====
`include "soc_bus_consts.svh"
`default_nettype none

module ram_slave (
    input  wire    clk_i,
    input  wire    rst_i,
    slave_if.slave port
);

    logic [`SOC_BUS_DW-1:0] mem [`SOC_RAM_WORDS];
    logic [`SOC_BUS_DW-1:0] rdata_q;
    logic                   wait_q;    // high in the second cycle of an access
    logic                   req;

    assign req        = port.rd | port.wr;
    assign port.stall = req & ~wait_q;  // one wait state
    assign port.rdata = rdata_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wait_q <= 1'b0;
        end else if (req) begin
            wait_q <= ~wait_q;         // set on entry, clear on completion
        end else begin
            wait_q <= 1'b0;
        end
    end

    // ************************************************************************
    // storage
    // ************************************************************************

    // read is sampled in the stall cycle so it is ready at completion
    always_ff @(posedge clk_i) begin
        if (port.rd && !wait_q) begin
            rdata_q <= mem[port.off];
        end
    end

    always_ff @(posedge clk_i) begin
        if (port.wr && wait_q) begin
            for (int b = 0; b < `SOC_BUS_BW; b++) begin
                if (port.be[b]) begin
                    mem[port.off][8*b +: 8] <= port.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/soc_bus_consts.svh ====
`ifndef SOC_BUS_CONSTS_SVH
`define SOC_BUS_CONSTS_SVH

`default_nettype none

// ************************************************************************
// bus widths
// ************************************************************************
`define SOC_BUS_AW 32                  // byte address
`define SOC_BUS_DW 32                  // one word
`define SOC_BUS_BW 4                   // byte enables per word

// ************************************************************************
// address map
// ************************************************************************
`define SOC_RAM_TAG     8'h00          // addr[31:24] of the ram region
`define SOC_RAM_WORDS   256
`define SOC_RAM_OW      8              // word offset bits, log2 of depth
`define SOC_GPIO_BASE   32'h1fd0_0400  // decoded on addr[31:8]
`define SOC_TICKER_BASE 32'h1fd0_0500  // decoded on addr[31:8]
`define SOC_IO_OW       6              // word offset bits inside a 256 byte page

`default_nettype wire

`endif

// ==== rtl/soc_bus_if.sv ====
`include "soc_bus_consts.svh"
`default_nettype none

// shared bus between the arbiter and the decoder
interface bus_if;
    logic [`SOC_BUS_AW-1:0] addr;
    logic [`SOC_BUS_BW-1:0] be;
    logic                   read;
    logic                   write;
    logic [`SOC_BUS_DW-1:0] wdata;
    logic [`SOC_BUS_DW-1:0] rdata;      // valid in the completion cycle
    logic                   stall;

    modport master (output addr, be, read, write, wdata, input rdata, stall);
    modport slave (input addr, be, read, write, wdata, output rdata, stall);
endinterface

// one per slave, driven by the decoder
interface slave_if #(parameter int OW = `SOC_IO_OW);
    logic [OW-1:0]          off;        // word offset inside the region
    logic [`SOC_BUS_BW-1:0] be;
    logic [`SOC_BUS_DW-1:0] wdata;
    logic                   rd;
    logic                   wr;
    logic [`SOC_BUS_DW-1:0] rdata;
    logic                   stall;

    modport master (output off, be, wdata, rd, wr, input rdata, stall);
    modport slave (input off, be, wdata, rd, wr, output rdata, stall);
endinterface

`default_nettype wire

// ==== rtl/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

    // ************************************************************************
    // decoder target
    // ************************************************************************
    typedef enum logic [1:0] {
        SEL_NONE   = 2'd0,             // unmapped, reads zero
        SEL_RAM    = 2'd1,
        SEL_GPIO   = 2'd2,
        SEL_TICKER = 2'd3
    } slave_sel_e;

    // ************************************************************************
    // arbiter grant lock
    // ************************************************************************

    // ARB_IDLE passes a request straight through, the other two
    // hold a grant while the slave stalls
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_M0   = 2'd1,               // instruction side locked
        ARB_M1   = 2'd2                // data side locked
    } arb_state_e;

endpackage

`default_nettype wire

// ==== rtl/soc_bus_top.sv ====
`include "soc_bus_consts.svh"
`default_nettype none

module soc_bus_top (
    input  wire                    clk_i,
    input  wire                    rst_i,

    // instruction side
    input  wire [`SOC_BUS_AW-1:0]  m0_addr_i,
    input  wire [`SOC_BUS_BW-1:0]  m0_be_i,
    input  wire                    m0_read_i,
    input  wire                    m0_write_i,
    input  wire [`SOC_BUS_DW-1:0]  m0_wdata_i,
    output logic [`SOC_BUS_DW-1:0] m0_rdata_o,
    output logic                   m0_stall_o,

    // data side
    input  wire [`SOC_BUS_AW-1:0]  m1_addr_i,
    input  wire [`SOC_BUS_BW-1:0]  m1_be_i,
    input  wire                    m1_read_i,
    input  wire                    m1_write_i,
    input  wire [`SOC_BUS_DW-1:0]  m1_wdata_i,
    output logic [`SOC_BUS_DW-1:0] m1_rdata_o,
    output logic                   m1_stall_o,

    input  wire [`SOC_BUS_DW-1:0]  gpio_i,
    output logic [`SOC_BUS_DW-1:0] gpio_o
);

    bus_if                            sys_bus ();
    slave_if #(.OW(`SOC_RAM_OW))      ram_bus ();
    slave_if #(.OW(`SOC_IO_OW))       gpio_bus ();
    slave_if #(.OW(`SOC_IO_OW))       ticker_bus ();

    bus_arbiter u_arbiter (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .m0_addr_i  (m0_addr_i),
        .m0_be_i    (m0_be_i),
        .m0_read_i  (m0_read_i),
        .m0_write_i (m0_write_i),
        .m0_wdata_i (m0_wdata_i),
        .m0_rdata_o (m0_rdata_o),
        .m0_stall_o (m0_stall_o),
        .m1_addr_i  (m1_addr_i),
        .m1_be_i    (m1_be_i),
        .m1_read_i  (m1_read_i),
        .m1_write_i (m1_write_i),
        .m1_wdata_i (m1_wdata_i),
        .m1_rdata_o (m1_rdata_o),
        .m1_stall_o (m1_stall_o),
        .bus        (sys_bus.master)
    );

    dbus_decoder u_decoder (
        .bus    (sys_bus.slave),
        .ram    (ram_bus.master),
        .gpio   (gpio_bus.master),
        .ticker (ticker_bus.master)
    );

    ram_slave u_ram (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .port  (ram_bus.slave)
    );

    gpio_slave u_gpio (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .port   (gpio_bus.slave),
        .gpio_i (gpio_i),
        .gpio_o (gpio_o)
    );

    ticker_slave u_ticker (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .port  (ticker_bus.slave)
    );

endmodule

`default_nettype wire

// ==== rtl/ticker_slave.sv ====
`include "soc_bus_consts.svh"
`default_nettype none

module ticker_slave (
    input  wire    clk_i,
    input  wire    rst_i,
    slave_if.slave port
);

    logic [`SOC_BUS_DW-1:0] cnt_q;
    logic [`SOC_BUS_DW-1:0] cnt_inc;
    logic [`SOC_BUS_DW-1:0] cnt_nxt;
    logic                   hit;

    assign hit     = (port.off == '0);
    assign cnt_inc = cnt_q + 1'b1;

    // disabled bytes keep counting
    always_comb begin
        cnt_nxt = cnt_inc;
        if (port.wr && hit) begin
            for (int b = 0; b < `SOC_BUS_BW; b++) begin
                if (port.be[b]) begin
                    cnt_nxt[8*b +: 8] = port.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_nxt;
        end
    end

    assign port.stall = 1'b0;                          // never waits
    assign port.rdata = (port.rd && hit) ? cnt_q : '0;

endmodule

`default_nettype wire

// ==== soc_bus.f ====
+incdir+rtl
rtl/soc_bus_pkg.sv
rtl/soc_bus_if.sv
rtl/bus_arbiter.sv
rtl/dbus_decoder.sv
rtl/ram_slave.sv
rtl/gpio_slave.sv
rtl/ticker_slave.sv
rtl/soc_bus_top.sv
dv/soc_bus_chk.sv
dv/soc_bus_tb.sv
